// ==== trap_config.svh ====
// rv32 machine-mode only; mtvec is always used as a base plus fixed offsets, no vectored mode
`ifndef TRAP_CONFIG_SVH
`define TRAP_CONFIG_SVH

`define TRAP_RESET_ADDR       32'h0000_0000

`define TRAP_CSR_MSTATUS      12'h300
`define TRAP_CSR_MIE          12'h304
`define TRAP_CSR_MTVEC        12'h305
`define TRAP_CSR_MEPC         12'h341
`define TRAP_CSR_MCAUSE       12'h342
`define TRAP_CSR_DCSR         12'h7B0
`define TRAP_CSR_DPC          12'h7B1

`define TRAP_CAUSE_EXTERNAL   {1'b1, 31'd11}
`define TRAP_CAUSE_SOFTWARE   {1'b1, 31'd3}
`define TRAP_CAUSE_TIMER      {1'b1, 31'd7}
`define TRAP_CAUSE_ECALL      {1'b0, 31'd11}
`define TRAP_CAUSE_FAST_BASE  32'h8000_0010  // fast index goes in bits 3:0

`define TRAP_OFS_ECALL        32'd8
`define TRAP_OFS_EXTERNAL     32'd32
`define TRAP_OFS_SOFTWARE     32'd36
`define TRAP_OFS_TIMER        32'd40
`define TRAP_OFS_FAST_BASE    32'd44  // plus 4 per fast index

`define TRAP_MIE_MEIE         11
`define TRAP_MIE_MSIE         3
`define TRAP_MIE_MTIE         7
`define TRAP_MSTATUS_MIE      3
`define TRAP_DCSR_STEP        2

`endif

// ==== trap_pkg.sv ====
// types only; widths fixed by rv32, dcsr cause occupies dcsr bits 8:6
`default_nettype none

package trap_pkg;

    typedef logic [31:0] word_t;      // data or address word
    typedef logic [11:0] csr_addr_t;  // csr address space

    // debug entry cause as stored in dcsr
    typedef enum logic [2:0] {
        NONE    = 3'd0,
        EBREAK  = 3'd1,
        TRIGGER = 3'd2,
        DBGREQ  = 3'd3,
        STEP    = 3'd4,
        HALT    = 3'd5
    } dbg_cause_e;

    // trap sequencer states
    typedef enum logic [2:0] {
        IDLE,
        W_MSTATUS,
        W_MEPC,
        W_DCSR,
        ASSERT
    } trap_state_e;

endpackage

`default_nettype wire

// ==== csr_trap_if.sv ====
// csr values are combinational from the register file; a trap write lands on the next clock edge
`timescale 1ns/100ps
`default_nettype none

interface csr_trap_if;
    import trap_pkg::*;

    word_t     mtvec;       // trap vector base
    word_t     mepc;
    word_t     mstatus;
    word_t     dpc;
    word_t     dcsr;
    logic      trap_we;     // one write per cycle
    csr_addr_t trap_waddr;
    word_t     trap_wdata;

    modport csr_side  (output mtvec, mepc, mstatus, dpc, dcsr,
                       input  trap_we, trap_waddr, trap_wdata);

    modport trap_side (input  mtvec, mepc, mstatus, dpc, dcsr,
                       output trap_we, trap_waddr, trap_wdata);

endinterface

`default_nettype wire

// ==== irq_prio.sv ====
// purely combinational; fast irqs ignore mie, mstatus.MIE and debug gating happen in trap_ctrl
`timescale 1ns/100ps
`default_nettype none
`include "trap_config.svh"

module irq_prio (
    input  logic            irq_software_i,
    input  logic            irq_timer_i,
    input  logic            irq_external_i,
    input  logic [14:0]     irq_fast_i,
    input  trap_pkg::word_t mie_i,
    output logic            irq_req_o,
    output trap_pkg::word_t irq_cause_o,
    output trap_pkg::word_t irq_offset_o
);
    import trap_pkg::*;

    logic       fast_hit;
    logic [3:0] fast_idx;

    // scan downwards so the lowest set line is the one kept
    always_comb begin
        fast_hit = 1'b0;
        fast_idx = 4'd0;
        for (int i = 14; i >= 0; i--) begin
            if (irq_fast_i[i]) begin
                fast_hit = 1'b1;
                fast_idx = 4'(i);
            end
        end
    end

    always_comb begin
        irq_req_o    = 1'b1;
        irq_cause_o  = '0;
        irq_offset_o = '0;
        if (fast_hit) begin
            irq_cause_o  = `TRAP_CAUSE_FAST_BASE | {28'd0, fast_idx};
            irq_offset_o = `TRAP_OFS_FAST_BASE + {26'd0, fast_idx, 2'b00};
        end else if (irq_external_i && mie_i[`TRAP_MIE_MEIE]) begin
            irq_cause_o  = `TRAP_CAUSE_EXTERNAL;
            irq_offset_o = `TRAP_OFS_EXTERNAL;
        end else if (irq_software_i && mie_i[`TRAP_MIE_MSIE]) begin
            irq_cause_o  = `TRAP_CAUSE_SOFTWARE;
            irq_offset_o = `TRAP_OFS_SOFTWARE;
        end else if (irq_timer_i && mie_i[`TRAP_MIE_MTIE]) begin
            irq_cause_o  = `TRAP_CAUSE_TIMER;
            irq_offset_o = `TRAP_OFS_TIMER;
        end else begin
            irq_req_o    = 1'b0;  // nothing pending or enabled
        end
    end

endmodule

`default_nettype wire

// ==== trap_ctrl.sv ====
// requests sampled only in IDLE with inst_valid_i; no back-pressure, caller waits for int_assert_o
`timescale 1ns/100ps
`default_nettype none
`include "trap_config.svh"

module trap_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            inst_valid_i,
    input  logic            inst_ecall_i,
    input  logic            inst_ebreak_i,
    input  logic            inst_mret_i,
    input  logic            inst_dret_i,
    input  trap_pkg::word_t inst_addr_i,
    input  logic            irq_req_i,
    input  trap_pkg::word_t irq_cause_i,
    input  trap_pkg::word_t irq_offset_i,
    input  logic            trigger_match_i,
    input  logic            debug_req_i,
    input  trap_pkg::word_t debug_halt_addr_i,
    csr_trap_if.trap_side   csr_if,
    output logic            stall_o,
    output logic            int_assert_o,
    output logic            debug_mode_o,
    output trap_pkg::word_t int_addr_o
);
    import trap_pkg::*;

    trap_state_e state_q, state_d;
    logic        debug_mode_q, debug_mode_d;
    word_t       assert_addr_q, assert_addr_d;  // redirect target
    word_t       return_addr_q;                 // becomes mepc
    dbg_cause_e  dcsr_cause_q, dcsr_cause_d;

    logic  in_idle;
    logic  ecall_take;
    logic  irq_take;
    logic  trap_take;
    logic  dbg_take;
    logic  mret_take;
    logic  dret_take;
    word_t trap_cause;
    word_t trap_offset;

    assign in_idle    = (state_q == IDLE);
    assign ecall_take = inst_valid_i & inst_ecall_i & ~debug_mode_q;
    assign irq_take   = inst_valid_i & irq_req_i & ~debug_mode_q
                      & csr_if.mstatus[`TRAP_MSTATUS_MIE];
    assign trap_take  = ecall_take | irq_take;
    assign mret_take  = inst_valid_i & inst_mret_i;
    assign dret_take  = inst_valid_i & inst_dret_i;

    // ecall outranks any pending interrupt
    assign trap_cause  = ecall_take ? `TRAP_CAUSE_ECALL : irq_cause_i;
    assign trap_offset = ecall_take ? `TRAP_OFS_ECALL : irq_offset_i;

    // debug entry causes, highest first
    always_comb begin
        dcsr_cause_d = NONE;
        if (inst_valid_i) begin
            if (trigger_match_i && !debug_mode_q) begin
                dcsr_cause_d = TRIGGER;
            end else if (inst_ebreak_i) begin
                dcsr_cause_d = EBREAK;
            end else if (debug_req_i && !debug_mode_q
                         && inst_addr_i == `TRAP_RESET_ADDR) begin
                dcsr_cause_d = HALT;
            end else if (debug_req_i && !debug_mode_q) begin
                dcsr_cause_d = DBGREQ;
            end else if (csr_if.dcsr[`TRAP_DCSR_STEP] && !debug_mode_q) begin
                dcsr_cause_d = STEP;
            end
        end
    end

    assign dbg_take = (dcsr_cause_d != NONE);

    always_comb begin
        state_d           = state_q;
        debug_mode_d      = debug_mode_q;
        assert_addr_d     = assert_addr_q;
        csr_if.trap_we    = 1'b0;
        csr_if.trap_waddr = '0;
        csr_if.trap_wdata = '0;
        case (state_q)
            IDLE: begin
                if (trap_take) begin
                    csr_if.trap_we    = 1'b1;
                    csr_if.trap_waddr = `TRAP_CSR_MCAUSE;
                    csr_if.trap_wdata = trap_cause;
                    assert_addr_d     = csr_if.mtvec + trap_offset;
                    state_d           = W_MSTATUS;
                end else if (dbg_take) begin
                    debug_mode_d  = 1'b1;
                    assert_addr_d = debug_halt_addr_i;
                    if (dcsr_cause_d == EBREAK) begin
                        state_d = ASSERT;  // dpc and dcsr left alone
                    end else begin
                        csr_if.trap_we    = 1'b1;
                        csr_if.trap_waddr = `TRAP_CSR_DPC;
                        csr_if.trap_wdata = inst_addr_i;  // halt only fires at the reset address
                        state_d           = W_DCSR;
                    end
                end else if (mret_take) begin
                    csr_if.trap_we    = 1'b1;
                    csr_if.trap_waddr = `TRAP_CSR_MSTATUS;
                    csr_if.trap_wdata = csr_if.mstatus;
                    csr_if.trap_wdata[`TRAP_MSTATUS_MIE] = 1'b1;  // re-enable irqs
                    assert_addr_d     = csr_if.mepc;
                    state_d           = ASSERT;
                end else if (dret_take) begin
                    debug_mode_d  = 1'b0;
                    assert_addr_d = csr_if.dpc;
                    state_d       = ASSERT;
                end
            end
            W_MSTATUS: begin
                csr_if.trap_we    = 1'b1;
                csr_if.trap_waddr = `TRAP_CSR_MSTATUS;
                csr_if.trap_wdata = csr_if.mstatus;
                csr_if.trap_wdata[`TRAP_MSTATUS_MIE] = 1'b0;  // mask further irqs
                state_d           = W_MEPC;
            end
            W_MEPC: begin
                csr_if.trap_we    = 1'b1;
                csr_if.trap_waddr = `TRAP_CSR_MEPC;
                csr_if.trap_wdata = return_addr_q;
                state_d           = ASSERT;
            end
            W_DCSR: begin
                csr_if.trap_we    = 1'b1;
                csr_if.trap_waddr = `TRAP_CSR_DCSR;
                csr_if.trap_wdata = {csr_if.dcsr[31:9], dcsr_cause_q, csr_if.dcsr[5:0]};
                state_d           = ASSERT;
            end
            ASSERT: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            debug_mode_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            debug_mode_q <= debug_mode_d;
        end
    end

    always_ff @(posedge clk) begin
        assert_addr_q <= assert_addr_d;
        if (in_idle && trap_take) begin
            return_addr_q <= inst_addr_i;
        end
        if (in_idle && dbg_take) begin
            dcsr_cause_q <= dcsr_cause_d;  // used one cycle later in W_DCSR
        end
    end

    // busy in the request cycle and every write state, released in ASSERT
    assign stall_o = (in_idle & (trap_take | dbg_take | mret_take | dret_take))
                   | (state_q == W_MSTATUS) | (state_q == W_MEPC) | (state_q == W_DCSR);

    assign int_assert_o = (state_q == ASSERT);
    assign int_addr_o   = assert_addr_q;
    assign debug_mode_o = debug_mode_q;

endmodule

`default_nettype wire

// ==== machine_csr.sv ====
// trap write beats a same-cycle software write; unknown addresses ignore writes and read as 0
`timescale 1ns/100ps
`default_nettype none
`include "trap_config.svh"

module machine_csr (
    input  logic                clk,
    input  logic                rst_n,
    csr_trap_if.csr_side        csr_if,
    input  logic                sw_we_i,
    input  trap_pkg::csr_addr_t sw_waddr_i,
    input  trap_pkg::word_t     sw_wdata_i,
    input  trap_pkg::csr_addr_t rd_addr_i,
    output trap_pkg::word_t     rd_data_o,
    output trap_pkg::word_t     mie_o
);
    import trap_pkg::*;

    word_t mtvec_q;
    word_t mepc_q;
    word_t mcause_q;
    word_t mstatus_q;
    word_t mie_q;
    word_t dpc_q;
    word_t dcsr_q;

    logic      we;
    csr_addr_t waddr;
    word_t     wdata;

    assign we    = csr_if.trap_we | sw_we_i;
    assign waddr = csr_if.trap_we ? csr_if.trap_waddr : sw_waddr_i;  // trap side first
    assign wdata = csr_if.trap_we ? csr_if.trap_wdata : sw_wdata_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mstatus_q <= '0;
            mie_q     <= '0;
            dpc_q     <= '0;
            dcsr_q    <= '0;
        end else if (we) begin
            case (waddr)
                `TRAP_CSR_MTVEC:   mtvec_q   <= wdata;
                `TRAP_CSR_MEPC:    mepc_q    <= wdata;
                `TRAP_CSR_MCAUSE:  mcause_q  <= wdata;
                `TRAP_CSR_MSTATUS: mstatus_q <= wdata;
                `TRAP_CSR_MIE:     mie_q     <= wdata;
                `TRAP_CSR_DPC:     dpc_q     <= wdata;
                `TRAP_CSR_DCSR:    dcsr_q    <= wdata;
                default: ;  // unmapped, dropped
            endcase
        end
    end

    // read port, same cycle
    always_comb begin
        case (rd_addr_i)
            `TRAP_CSR_MTVEC:   rd_data_o = mtvec_q;
            `TRAP_CSR_MEPC:    rd_data_o = mepc_q;
            `TRAP_CSR_MCAUSE:  rd_data_o = mcause_q;
            `TRAP_CSR_MSTATUS: rd_data_o = mstatus_q;
            `TRAP_CSR_MIE:     rd_data_o = mie_q;
            `TRAP_CSR_DPC:     rd_data_o = dpc_q;
            `TRAP_CSR_DCSR:    rd_data_o = dcsr_q;
            default:           rd_data_o = '0;
        endcase
    end

    assign csr_if.mtvec   = mtvec_q;
    assign csr_if.mepc    = mepc_q;
    assign csr_if.mstatus = mstatus_q;
    assign csr_if.dpc     = dpc_q;
    assign csr_if.dcsr    = dcsr_q;
    assign mie_o          = mie_q;

endmodule

`default_nettype wire

// ==== trap_unit_top.sv ====
// one instruction in flight; drive the next only after int_assert_o, all strobes one cycle wide
`timescale 1ns/100ps
`default_nettype none

module trap_unit_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_valid_i,
    input  logic                inst_ecall_i,
    input  logic                inst_ebreak_i,
    input  logic                inst_mret_i,
    input  logic                inst_dret_i,
    input  trap_pkg::word_t     inst_addr_i,
    input  logic                irq_software_i,
    input  logic                irq_timer_i,
    input  logic                irq_external_i,
    input  logic [14:0]         irq_fast_i,
    input  logic                trigger_match_i,
    input  logic                debug_req_i,
    input  trap_pkg::word_t     debug_halt_addr_i,
    input  logic                csr_wr_en_i,
    input  trap_pkg::csr_addr_t csr_wr_addr_i,
    input  trap_pkg::word_t     csr_wr_data_i,
    input  trap_pkg::csr_addr_t csr_rd_addr_i,
    output trap_pkg::word_t     csr_rd_data_o,
    output logic                stall_o,
    output logic                int_assert_o,
    output trap_pkg::word_t     int_addr_o,
    output logic                debug_mode_o
);
    import trap_pkg::*;

    word_t mie;         // straight from the csr file
    logic  irq_req;
    word_t irq_cause;
    word_t irq_offset;

    csr_trap_if csr_bus ();

    irq_prio u_irq_prio (
        .irq_software_i (irq_software_i),
        .irq_timer_i    (irq_timer_i),
        .irq_external_i (irq_external_i),
        .irq_fast_i     (irq_fast_i),
        .mie_i          (mie),
        .irq_req_o      (irq_req),
        .irq_cause_o    (irq_cause),
        .irq_offset_o   (irq_offset)
    );

    trap_ctrl u_trap_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_valid_i      (inst_valid_i),
        .inst_ecall_i      (inst_ecall_i),
        .inst_ebreak_i     (inst_ebreak_i),
        .inst_mret_i       (inst_mret_i),
        .inst_dret_i       (inst_dret_i),
        .inst_addr_i       (inst_addr_i),
        .irq_req_i         (irq_req),
        .irq_cause_i       (irq_cause),
        .irq_offset_i      (irq_offset),
        .trigger_match_i   (trigger_match_i),
        .debug_req_i       (debug_req_i),
        .debug_halt_addr_i (debug_halt_addr_i),
        .csr_if            (csr_bus.trap_side),
        .stall_o           (stall_o),
        .int_assert_o      (int_assert_o),
        .debug_mode_o      (debug_mode_o),
        .int_addr_o        (int_addr_o)
    );

    machine_csr u_machine_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_if     (csr_bus.csr_side),
        .sw_we_i    (csr_wr_en_i),
        .sw_waddr_i (csr_wr_addr_i),
        .sw_wdata_i (csr_wr_data_i),
        .rd_addr_i  (csr_rd_addr_i),
        .rd_data_o  (csr_rd_data_o),
        .mie_o      (mie)
    );

endmodule

`default_nettype wire

// ==== trap_unit_chk.sv ====
// bound to trap_unit_top; assumes requests are only issued while the trap sequencer is idle
`timescale 1ns/100ps
`default_nettype none

module trap_unit_chk (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic inst_valid_i,
    input wire logic inst_ecall_i,
    input wire logic debug_mode_o,
    input wire logic stall_o,
    input wire logic int_assert_o
);

    // redirect is a single-cycle strobe
    a_pulse_one_cycle : assert property (@(posedge clk) disable iff (!rst_n)
        int_assert_o |=> !int_assert_o)
        else $error("int_assert_o held longer than one cycle");

    a_no_stall_in_assert : assert property (@(posedge clk) disable iff (!rst_n)
        int_assert_o |-> !stall_o)
        else $error("stall_o high during int_assert_o");

    // ecall outside debug mode: mcause, mstatus, mepc, then redirect
    a_trap_latency : assert property (@(posedge clk) disable iff (!rst_n)
        (inst_valid_i && inst_ecall_i && !debug_mode_o) |-> ##3 int_assert_o)
        else $error("int_assert_o not three cycles after trap request");

    a_quiet_in_reset : assert property (@(posedge clk)
        !rst_n |-> (!int_assert_o && !stall_o && !debug_mode_o))
        else $error("control output active during reset");

endmodule

bind trap_unit_top trap_unit_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid_i (inst_valid_i),
    .inst_ecall_i (inst_ecall_i),
    .debug_mode_o (debug_mode_o),
    .stall_o      (stall_o),
    .int_assert_o (int_assert_o)
);

`default_nettype wire

// ==== tb_trap_unit.sv ====
// one instruction at a time; expected values come from a shadow CSR image and ref_model
`timescale 1ns/100ps
`default_nettype none
`include "trap_config.svh"

module tb_trap_unit;
    import trap_pkg::*;

    localparam int N_TRANS = 48;
    localparam int K_PLAIN = 0;
    localparam int K_ECALL = 1;
    localparam int K_EBREAK = 2;
    localparam int K_MRET = 3;
    localparam int K_DRET = 4;

    typedef struct packed {
        word_t mtvec;
        word_t mepc;
        word_t mcause;
        word_t mstatus;
        word_t mie;
        word_t dpc;
        word_t dcsr;
        logic  dbg;
    } image_t;

    logic clk, rst_n;
    logic inst_valid_i, inst_ecall_i, inst_ebreak_i, inst_mret_i, inst_dret_i;
    word_t inst_addr_i;
    logic irq_software_i, irq_timer_i, irq_external_i;
    logic [14:0] irq_fast_i;
    logic trigger_match_i, debug_req_i;
    word_t debug_halt_addr_i;
    logic csr_wr_en_i;
    csr_addr_t csr_wr_addr_i, csr_rd_addr_i;
    word_t csr_wr_data_i, csr_rd_data_o, int_addr_o;
    logic stall_o, int_assert_o, debug_mode_o;

    integer seed;
    word_t rnd, a;
    int errors, test_errs, tests_run, tests_failed;
    int cyc, req_cyc, pulses, exp_lat, stall_cnt;
    word_t exp_target;
    image_t shadow;
    csr_addr_t csr_tab [7];

    trap_unit_top i_dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("FAIL t=%0t %s got 0x%08h exp 0x%08h", $time, name, got, exp);
        errors++;
        test_errs++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    // expected redirect, latency and CSR image after one instruction
    function automatic image_t ref_model(input int kind, input word_t addr, input image_t cur,
                                         input logic [14:0] fast, input logic sw, input logic tm,
                                         input logic ext, input logic trig, input logic dreq,
                                         input word_t halt, output logic take, output int lat,
                                         output word_t tgt);
        image_t nxt;
        logic irq;
        word_t icause, iofs;
        logic [2:0] dcause;
        nxt = cur;
        take = 1'b0;
        lat = 0;
        tgt = '0;
        irq = 1'b0;
        icause = '0;
        iofs = '0;
        dcause = 3'd0;
        for (int i = 0; i < 15; i++) begin
            if (fast[i] && !irq) begin
                irq = 1'b1;
                icause = {1'b1, 26'd0, 1'b1, 4'(i)};
                iofs = 32'(44 + 4 * i);
            end
        end
        if (!irq && ext && cur.mie[11]) begin
            irq = 1'b1;
            icause = {1'b1, 31'd11};
            iofs = 32'd32;
        end else if (!irq && sw && cur.mie[3]) begin
            irq = 1'b1;
            icause = {1'b1, 31'd3};
            iofs = 32'd36;
        end else if (!irq && tm && cur.mie[7]) begin
            irq = 1'b1;
            icause = {1'b1, 31'd7};
            iofs = 32'd40;
        end
        if (!cur.dbg && (kind == K_ECALL || (irq && cur.mstatus[3]))) begin
            take = 1'b1;
            lat = 3;
            nxt.mcause = (kind == K_ECALL) ? {1'b0, 31'd11} : icause;
            tgt = cur.mtvec + ((kind == K_ECALL) ? 32'd8 : iofs);
            nxt.mstatus[3] = 1'b0;
            nxt.mepc = addr;
            return nxt;
        end
        if (trig && !cur.dbg) dcause = 3'd2;
        else if (kind == K_EBREAK) dcause = 3'd1;
        else if (dreq && !cur.dbg && addr == 32'd0) dcause = 3'd5;
        else if (dreq && !cur.dbg) dcause = 3'd3;
        else if (cur.dcsr[2] && !cur.dbg) dcause = 3'd4;
        if (dcause != 3'd0) begin
            take = 1'b1;
            nxt.dbg = 1'b1;
            tgt = halt;
            lat = (dcause == 3'd1) ? 1 : 2;
            if (dcause != 3'd1) begin
                nxt.dpc = addr;
                nxt.dcsr[8:6] = dcause;
            end
        end else if (kind == K_MRET) begin
            take = 1'b1;
            lat = 1;
            tgt = cur.mepc;
            nxt.mstatus[3] = 1'b1;
        end else if (kind == K_DRET) begin
            take = 1'b1;
            lat = 1;
            tgt = cur.dpc;
            nxt.dbg = 1'b0;
        end
        return nxt;
    endfunction

    // compare process, sees every redirect pulse
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (inst_valid_i) req_cyc = cyc;
        if (stall_o) stall_cnt = stall_cnt + 1;
        if (int_assert_o) begin
            pulses = pulses + 1;
            if (int_addr_o !== exp_target) report_mismatch("int_addr_o", int_addr_o, exp_target);
            if (cyc - req_cyc != exp_lat) begin
                report_problem($sformatf("redirect came %0d cycles after request, expected %0d",
                                         cyc - req_cyc, exp_lat));
            end
            // stall covers every cycle from the request up to the pulse
            if (stall_cnt != exp_lat) begin
                report_problem($sformatf("stall_o was high for %0d cycles, expected %0d",
                                         stall_cnt, exp_lat));
            end
            stall_cnt = 0;
        end
    end

    task automatic read_csr(input csr_addr_t addr, output word_t data);
        @(posedge clk);
        csr_rd_addr_i <= addr;
        @(negedge clk);
        data = csr_rd_data_o;
    endtask

    task automatic sw_write(input csr_addr_t addr, input word_t data);
        @(posedge clk);
        csr_wr_en_i   <= 1'b1;
        csr_wr_addr_i <= addr;
        csr_wr_data_i <= data;
        @(posedge clk);
        csr_wr_en_i   <= 1'b0;
        case (addr)
            `TRAP_CSR_MTVEC:   shadow.mtvec = data;
            `TRAP_CSR_MEPC:    shadow.mepc = data;
            `TRAP_CSR_MCAUSE:  shadow.mcause = data;
            `TRAP_CSR_MSTATUS: shadow.mstatus = data;
            `TRAP_CSR_MIE:     shadow.mie = data;
            `TRAP_CSR_DPC:     shadow.dpc = data;
            `TRAP_CSR_DCSR:    shadow.dcsr = data;
            default: ;
        endcase
    endtask

    task automatic check_csrs(input image_t e);
        word_t d;
        read_csr(`TRAP_CSR_MCAUSE, d);
        if (d !== e.mcause) report_mismatch("mcause", d, e.mcause);
        read_csr(`TRAP_CSR_MEPC, d);
        if (d !== e.mepc) report_mismatch("mepc", d, e.mepc);
        read_csr(`TRAP_CSR_MSTATUS, d);
        if (d !== e.mstatus) report_mismatch("mstatus", d, e.mstatus);
        read_csr(`TRAP_CSR_DPC, d);
        if (d !== e.dpc) report_mismatch("dpc", d, e.dpc);
        read_csr(`TRAP_CSR_DCSR, d);
        if (d !== e.dcsr) report_mismatch("dcsr", d, e.dcsr);
        if (debug_mode_o !== e.dbg) report_mismatch("debug_mode_o", 32'(debug_mode_o), 32'(e.dbg));
    endtask

    task automatic run_inst(input int kind, input word_t addr, input logic [14:0] fast,
                            input logic sw, input logic tm, input logic ext,
                            input logic trig, input logic dreq);
        image_t nxt;
        logic take;
        int lat;
        word_t tgt;
        int seen;
        nxt = ref_model(kind, addr, shadow, fast, sw, tm, ext, trig, dreq,
                        debug_halt_addr_i, take, lat, tgt);
        exp_target = tgt;
        exp_lat = lat;
        seen = pulses;
        @(posedge clk);
        inst_valid_i    <= 1'b1;
        inst_ecall_i    <= (kind == K_ECALL);
        inst_ebreak_i   <= (kind == K_EBREAK);
        inst_mret_i     <= (kind == K_MRET);
        inst_dret_i     <= (kind == K_DRET);
        inst_addr_i     <= addr;
        irq_fast_i      <= fast;
        irq_software_i  <= sw;
        irq_timer_i     <= tm;
        irq_external_i  <= ext;
        trigger_match_i <= trig;
        debug_req_i     <= dreq;
        @(posedge clk);
        {inst_valid_i, inst_ecall_i, inst_ebreak_i, inst_mret_i, inst_dret_i} <= '0;
        {irq_software_i, irq_timer_i, irq_external_i, trigger_match_i, debug_req_i} <= '0;
        irq_fast_i <= '0;
        for (int n = 0; n < 12 && pulses == seen; n++) @(negedge clk);
        if (take && pulses == seen) report_problem("no redirect pulse after instruction");
        if (!take && pulses != seen) report_problem("unexpected redirect pulse");
        check_csrs(nxt);
        shadow = nxt;
    endtask

    task automatic next_addr(output word_t addr);
        rnd = $random(seed);
        addr = {rnd[31:3], 3'b100};  // word aligned, never the reset address
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (test_errs == 0) ? "ok" : "errors");
        test_errs = 0;
    endtask

    initial begin
        #(N_TRANS * 200 * 4);
        $display("ERROR watchdog expired, DUT stopped responding");
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed = 2;
        errors = 0;
        test_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        cyc = 0;
        req_cyc = 0;
        pulses = 0;
        exp_lat = 0;
        stall_cnt = 0;
        exp_target = '0;
        shadow = '0;
        csr_tab = '{`TRAP_CSR_MTVEC, `TRAP_CSR_MEPC, `TRAP_CSR_MCAUSE, `TRAP_CSR_MSTATUS,
                    `TRAP_CSR_MIE, `TRAP_CSR_DPC, `TRAP_CSR_DCSR};
        rst_n = 1'b0;
        {inst_valid_i, inst_ecall_i, inst_ebreak_i, inst_mret_i, inst_dret_i} = '0;
        {irq_software_i, irq_timer_i, irq_external_i, trigger_match_i, debug_req_i} = '0;
        irq_fast_i = '0;
        inst_addr_i = '0;
        debug_halt_addr_i = 32'h0000_0800;
        csr_wr_en_i = 1'b0;
        csr_wr_addr_i = '0;
        csr_wr_data_i = '0;
        csr_rd_addr_i = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        rnd = $random(seed);
        sw_write(`TRAP_CSR_MTVEC, {rnd[31:8], 8'h00});
        sw_write(`TRAP_CSR_MIE, 32'h888);
        sw_write(`TRAP_CSR_MSTATUS, 32'h8);
        next_addr(a);
        run_inst(K_ECALL, a, '0, 0, 0, 0, 0, 0);
        end_test("ecall");

        for (int i = 0; i < 8; i++) begin
            sw_write(`TRAP_CSR_MSTATUS, 32'h8);
            next_addr(a);
            rnd = $random(seed);
            run_inst(K_PLAIN, a, rnd[16] ? 15'd0 : rnd[14:0], rnd[17], rnd[18], rnd[19], 0, 0);
        end
        sw_write(`TRAP_CSR_MSTATUS, 32'h8);
        run_inst(K_PLAIN, 32'h100, '0, 1, 1, 1, 0, 0);  // external first
        sw_write(`TRAP_CSR_MIE, 32'h088);
        sw_write(`TRAP_CSR_MSTATUS, 32'h8);
        run_inst(K_PLAIN, 32'h104, '0, 1, 1, 1, 0, 0);
        sw_write(`TRAP_CSR_MIE, 32'h080);
        sw_write(`TRAP_CSR_MSTATUS, 32'h8);
        run_inst(K_PLAIN, 32'h108, '0, 1, 1, 1, 0, 0);
        sw_write(`TRAP_CSR_MSTATUS, 32'h0);
        run_inst(K_PLAIN, 32'h10c, 15'h0101, 1, 1, 1, 0, 0);  // globally masked
        end_test("interrupt priority");

        next_addr(a);
        sw_write(`TRAP_CSR_MEPC, a);
        run_inst(K_MRET, 32'h200, '0, 0, 0, 0, 0, 0);
        run_inst(K_EBREAK, 32'h204, '0, 0, 0, 0, 0, 0);
        next_addr(a);
        sw_write(`TRAP_CSR_DPC, a);
        run_inst(K_DRET, 32'h804, '0, 0, 0, 0, 0, 0);
        end_test("mret and dret");

        next_addr(a);
        run_inst(K_PLAIN, a, '0, 0, 0, 0, 0, 1);
        sw_write(`TRAP_CSR_MIE, 32'h888);
        sw_write(`TRAP_CSR_MSTATUS, 32'h8);
        run_inst(K_PLAIN, 32'h808, 15'h0004, 1, 1, 1, 0, 0);  // ignored in debug mode
        run_inst(K_DRET, 32'h80c, '0, 0, 0, 0, 0, 0);
        end_test("debug request");

        run_inst(K_EBREAK, 32'h300, '0, 0, 0, 0, 0, 0);
        run_inst(K_DRET, 32'h800, '0, 0, 0, 0, 0, 0);
        next_addr(a);
        run_inst(K_PLAIN, a, '0, 0, 0, 0, 1, 0);
        run_inst(K_DRET, 32'h800, '0, 0, 0, 0, 0, 0);
        run_inst(K_PLAIN, `TRAP_RESET_ADDR, '0, 0, 0, 0, 0, 1);
        run_inst(K_DRET, 32'h800, '0, 0, 0, 0, 0, 0);
        sw_write(`TRAP_CSR_DCSR, shadow.dcsr | 32'h4);
        next_addr(a);
        run_inst(K_PLAIN, a, '0, 0, 0, 0, 0, 0);
        sw_write(`TRAP_CSR_DCSR, shadow.dcsr & ~32'h4);
        run_inst(K_DRET, 32'h800, '0, 0, 0, 0, 0, 0);
        end_test("debug causes");

        for (int i = 0; i < 10; i++) begin
            word_t d;
            word_t w;
            int idx;
            rnd = $random(seed);
            idx = (rnd[2:0] == 3'd7) ? 0 : int'(rnd[2:0]);
            w = $random(seed);
            sw_write(csr_tab[idx], w);
            read_csr(csr_tab[idx], d);
            if (d !== w) report_mismatch("csr_rd_data_o", d, w);
            check_csrs(shadow);
        end
        end_test("software csr writes");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
trap_pkg.sv
csr_trap_if.sv
irq_prio.sv
trap_ctrl.sv
machine_csr.sv
trap_unit_top.sv
trap_unit_chk.sv
tb_trap_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the trap unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_trap_unit \
    -f vlog.f \
    -o sim_trap_unit

./obj_dir/sim_trap_unit | tee sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
